//--- Bender.yml
package:
  name: reservation_station

export_include_dirs:
  - .

sources:
  - files:
      - instr_pkg.sv
      - rs_pkg.sv
      - rs_reg_trk.sv
      - rs_entry.sv
      - rs_age_matrix.sv
      - reservation_station.sv
  - target: simulation
    files:
      - rs_tb_clk.sv
      - rs_tb.sv

//--- instr_pkg.sv
`include "rs_cfg.svh"

package instr_pkg;

    typedef enum logic [3:0] {
        OP_NOP,
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLL,
        OP_SRL
    } t_op;

    typedef struct packed {
        logic [`ARCH_IDX_W-1:0] areg;
        logic                   valid;
    } t_src_descr;

    // Src2 is read either as a register or as an immediate
    typedef union packed {
        struct packed {
            logic [`IMM_W-`ARCH_IDX_W-2:0] pad;
            t_src_descr                    descr;
        } reg_view;
        logic [`IMM_W-1:0] imm;
    } t_src2_opnd;

    typedef struct packed {
        t_op                    op;
        logic [`ARCH_IDX_W-1:0] dst;
        t_src_descr             src1;
        t_src2_opnd             src2;
        logic                   src2_is_imm;
    } t_uinstr;

endpackage

//--- reservation_station.sv
`timescale 1ns/1ps
`include "rs_cfg.svh"

module reservation_station
    import rs_pkg::*;
(
    input  logic        clk,
    input  logic        reset,

    input  logic        disp_valid,
    input  t_disp_pkt   disp_pkt,
    output logic        disp_ready,

    input  logic        iprf_wr_en  [`IPRF_NUM_WRITES-1:0],
    input  t_prf_wr_pkt iprf_wr_pkt [`IPRF_NUM_WRITES-1:0],

    input  logic        issue_ready,
    output logic        issue_valid,
    output t_iss_pkt    issue_pkt
);

    localparam int N = `RS_NUM_ENTRIES;

    logic [N-1:0] ent_valid;
    logic [N-1:0] ent_req;
    logic [N-1:0] ent_gnt;
    logic [N-1:0] ent_oldest;
    logic [N-1:0] free_oh;
    logic [N-1:0] alloc_oh;
    logic         free_found;
    t_iss_pkt     ent_pkt [N];

    // Lowest-numbered free entry
    always_comb begin
        free_oh = '0;
        free_found = 1'b0;
        for (int i = 0; i < N; i++) begin
            if (!ent_valid[i] && !free_found) begin
                free_oh[i] = 1'b1;
                free_found = 1'b1;
            end
        end
    end

    assign disp_ready = free_found;
    assign alloc_oh = free_oh & {N{disp_valid}};

    for (genvar e = 0; e < N; e++) begin : g_ent
        rs_entry rs_entry_i (
            .clk         (clk),
            .reset       (reset),
            .alloc       (alloc_oh[e]),
            .alloc_pkt   (disp_pkt),
            .iprf_wr_en  (iprf_wr_en),
            .iprf_wr_pkt (iprf_wr_pkt),
            .gnt_issue   (ent_gnt[e]),
            .valid       (ent_valid[e]),
            .req_issue   (ent_req[e]),
            .issue_pkt   (ent_pkt[e])
        );
    end

    rs_age_matrix rs_age_matrix_i (
        .clk         (clk),
        .reset       (reset),
        .alloc       (alloc_oh),
        .req         (ent_req),
        .issue_ready (issue_ready),
        .oldest      (ent_oldest),
        .gnt         (ent_gnt)
    );

    assign issue_valid = |ent_req;

    // One-hot AND-OR select of the oldest ready entry
    // Ungated by issue_ready so the packet holds under back-pressure
    always_comb begin
        issue_pkt = '0;
        for (int i = 0; i < N; i++) begin
            if (ent_oldest[i]) begin
                issue_pkt = issue_pkt | ent_pkt[i];
            end
        end
    end

endmodule

//--- rs_age_matrix.sv
`timescale 1ns/1ps
`include "rs_cfg.svh"

module rs_age_matrix (
    input  logic                       clk,
    input  logic                       reset,
    input  logic [`RS_NUM_ENTRIES-1:0] alloc,
    input  logic [`RS_NUM_ENTRIES-1:0] req,
    input  logic                       issue_ready,
    output logic [`RS_NUM_ENTRIES-1:0] oldest,
    output logic [`RS_NUM_ENTRIES-1:0] gnt
);

    localparam int N = `RS_NUM_ENTRIES;

    // older[i][j] set means entry i was allocated before entry j
    logic [N-1:0] older [N];
    logic [N-1:0] blocked;

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < N; i++) begin
                older[i] <= '0;
            end
        end else begin
            for (int i = 0; i < N; i++) begin
                for (int j = 0; j < N; j++) begin
                    if (i != j) begin
                        // New entry is younger than everyone else
                        if (alloc[i]) begin
                            older[i][j] <= 1'b0;
                        end else if (alloc[j]) begin
                            older[i][j] <= 1'b1;
                        end
                    end
                end
            end
        end
    end

    // A requester loses if any other requester is older
    always_comb begin
        blocked = '0;
        for (int i = 0; i < N; i++) begin
            for (int j = 0; j < N; j++) begin
                if ((i != j) && req[j] && older[j][i]) begin
                    blocked[i] = 1'b1;
                end
            end
        end
    end

    assign oldest = req & ~blocked;

    // Back-pressure holds everything in place
    assign gnt = oldest & {N{issue_ready}};

endmodule

//--- rs_cfg.svh
`ifndef RS_CFG_SVH
`define RS_CFG_SVH

// Station geometry
`define RS_NUM_ENTRIES 4

// Register file write ports observed for wakeup
`define IPRF_NUM_WRITES 2

// Index widths
`define PRF_IDX_W 6
`define ROBID_W 5
`define ARCH_IDX_W 5

// Immediate and operand data widths
`define IMM_W 12
`define DATA_W 32

`endif

//--- rs_entry.sv
`timescale 1ns/1ps
`include "rs_cfg.svh"

module rs_entry
    import instr_pkg::*, rs_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        alloc,
    input  t_disp_pkt   alloc_pkt,
    input  logic        iprf_wr_en  [`IPRF_NUM_WRITES-1:0],
    input  t_prf_wr_pkt iprf_wr_pkt [`IPRF_NUM_WRITES-1:0],
    input  logic        gnt_issue,
    output logic        valid,
    output logic        req_issue,
    output t_iss_pkt    issue_pkt
);

    typedef enum logic {
        IDLE,
        VALID
    } t_ent_state;

    t_ent_state state;
    t_ent_state state_nxt;

    t_disp_pkt payload;

    t_rs_reg_trk_static trk_static [NUM_SOURCES];
    t_prf_idx           trk_psrc   [NUM_SOURCES];
    logic [NUM_SOURCES-1:0] src_ready;

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: if (alloc) state_nxt = VALID;
            VALID: if (gnt_issue) state_nxt = IDLE;
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    assign valid = (state == VALID);

    always_ff @(posedge clk) begin
        if (alloc) begin
            payload <= alloc_pkt;
        end
    end

    // Tracker start state comes straight from rename
    assign trk_static[SRC1].psrc = alloc_pkt.rename.psrc1;
    assign trk_static[SRC1].psrc_pend = alloc_pkt.rename.psrc1_pend;
    assign trk_static[SRC2].psrc = alloc_pkt.rename.psrc2;
    // An immediate never waits
    assign trk_static[SRC2].psrc_pend = alloc_pkt.rename.psrc2_pend &
                                        ~alloc_pkt.uinstr.src2_is_imm;

    for (genvar s = 0; s < NUM_SOURCES; s++) begin : g_trk
        rs_reg_trk rs_reg_trk_i (
            .clk          (clk),
            .reset        (reset),
            .alloc        (alloc),
            .alloc_static (trk_static[s]),
            .iprf_wr_en   (iprf_wr_en),
            .iprf_wr_pkt  (iprf_wr_pkt),
            .psrc         (trk_psrc[s]),
            .ready        (src_ready[s])
        );
    end

    assign req_issue = valid & (&src_ready);

    always_comb begin
        issue_pkt.uinstr = payload.uinstr;
        issue_pkt.robid = payload.rename.robid;
        issue_pkt.pdst = payload.rename.pdst;
        issue_pkt.psrc1 = trk_psrc[SRC1];
        issue_pkt.psrc2 = trk_psrc[SRC2];
        issue_pkt.src1_val = '0;
        issue_pkt.src2_val = '0;
    end

endmodule

//--- rs_pkg.sv
`include "rs_cfg.svh"

package rs_pkg;

    import instr_pkg::*;

    // Source slots within an entry
    localparam int SRC1 = 0;
    localparam int SRC2 = 1;
    localparam int NUM_SOURCES = 2;

    typedef logic [`PRF_IDX_W-1:0] t_prf_idx;
    typedef logic [`ROBID_W-1:0] t_rob_id;
    typedef logic [`DATA_W-1:0] t_word;

    typedef struct packed {
        t_rob_id  robid;
        t_prf_idx pdst;
        t_prf_idx psrc1;
        t_prf_idx psrc2;
        logic     psrc1_pend;
        logic     psrc2_pend;
    } t_rename;

    typedef struct packed {
        t_uinstr uinstr;
        t_rename rename;
    } t_disp_pkt;

    typedef struct packed {
        t_prf_idx preg;
    } t_prf_wr_pkt;

    // Start state of one source tracker
    typedef struct packed {
        t_prf_idx psrc;
        logic     psrc_pend;
    } t_rs_reg_trk_static;

    typedef struct packed {
        t_uinstr  uinstr;
        t_rob_id  robid;
        t_prf_idx pdst;
        t_prf_idx psrc1;
        t_prf_idx psrc2;
        t_word    src1_val;
        t_word    src2_val;
    } t_iss_pkt;

endpackage

//--- rs_reg_trk.sv
`timescale 1ns/1ps
`include "rs_cfg.svh"

module rs_reg_trk
    import rs_pkg::*;
(
    input  logic               clk,
    input  logic               reset,
    input  logic               alloc,
    input  t_rs_reg_trk_static alloc_static,
    input  logic               iprf_wr_en  [`IPRF_NUM_WRITES-1:0],
    input  t_prf_wr_pkt        iprf_wr_pkt [`IPRF_NUM_WRITES-1:0],
    output t_prf_idx           psrc,
    output logic               ready
);

    logic pend;
    logic hit_alloc;
    logic hit_held;

    // Compare every write port against the incoming and the held register
    always_comb begin
        hit_alloc = 1'b0;
        hit_held = 1'b0;
        for (int i = 0; i < `IPRF_NUM_WRITES; i++) begin
            if (iprf_wr_en[i] && (iprf_wr_pkt[i].preg == alloc_static.psrc)) begin
                hit_alloc = 1'b1;
            end
            if (iprf_wr_en[i] && (iprf_wr_pkt[i].preg == psrc)) begin
                hit_held = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pend <= 1'b0;
        end else if (alloc) begin
            // Same-cycle write must not be missed
            pend <= alloc_static.psrc_pend & ~hit_alloc;
        end else if (hit_held) begin
            pend <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (alloc) begin
            psrc <= alloc_static.psrc;
        end
    end

    assign ready = ~pend;

endmodule

//--- rs_tb.sv
`timescale 1ns/1ps
`include "rs_cfg.svh"

module rs_tb
    import instr_pkg::*, rs_pkg::*;
();

    typedef struct {
        int             test;
        logic           disp_valid;
        t_disp_pkt      disp_pkt;
        logic [1:0]     wr_en;
        t_prf_idx [1:0] wr_reg;
        logic           issue_ready;
        logic           exp_disp_ready;
        logic           exp_issue_valid;
        t_iss_pkt       exp_pkt;
    } t_step;

    // Outstanding micro-op in the reference model
    typedef struct {
        t_iss_pkt pkt;
        logic     pend1;
        logic     pend2;
    } t_model_ent;

    logic        clk;
    logic        reset;
    logic        disp_valid;
    t_disp_pkt   disp_pkt;
    logic        disp_ready;
    logic        iprf_wr_en  [`IPRF_NUM_WRITES-1:0];
    t_prf_wr_pkt iprf_wr_pkt [`IPRF_NUM_WRITES-1:0];
    logic        issue_ready;
    logic        issue_valid;
    t_iss_pkt    issue_pkt;

    t_step       step_q [$];
    t_model_ent  model_q [$];
    string       test_names [6] = '{"reset_and_simple", "wakeup", "same_cycle_wakeup",
                                    "imm_src2", "age_order_backpressure", "full_and_reuse"};
    int unsigned lcg_state = 19;
    int          timeout_limit = 1000;
    int          cycles = 0;
    int          checks = 0;
    int          errors = 0;
    int          test_errors = 0;
    int          tests_run = 0;
    int          tests_failed = 0;

    rs_tb_clk rs_tb_clk_i (
        .clk   (clk),
        .reset (reset)
    );

    reservation_station reservation_station_i (
        .clk         (clk),
        .reset       (reset),
        .disp_valid  (disp_valid),
        .disp_pkt    (disp_pkt),
        .disp_ready  (disp_ready),
        .iprf_wr_en  (iprf_wr_en),
        .iprf_wr_pkt (iprf_wr_pkt),
        .issue_ready (issue_ready),
        .issue_valid (issue_valid),
        .issue_pkt   (issue_pkt)
    );

    function int unsigned lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // Random registers stay below 32, pending ones in the tests sit at 40 and up
    function t_prf_idx rand_reg();
        return t_prf_idx'((lcg_next() >> 16) % 32);
    endfunction

    function automatic t_disp_pkt make_pkt(input t_prf_idx psrc1, input logic p1,
                                           input t_prf_idx psrc2, input logic p2,
                                           input logic is_imm);
        t_disp_pkt   p;
        logic [31:0] r;
        p = '0;
        r = lcg_next();
        p.uinstr.op = t_op'({1'b0, r[2:0]});
        p.uinstr.dst = r[8 +: `ARCH_IDX_W];
        p.uinstr.src1.areg = r[16 +: `ARCH_IDX_W];
        p.uinstr.src1.valid = 1'b1;
        if (is_imm) begin
            p.uinstr.src2.imm = r[20 +: `IMM_W];
        end else begin
            p.uinstr.src2.reg_view.descr.areg = r[24 +: `ARCH_IDX_W];
            p.uinstr.src2.reg_view.descr.valid = 1'b1;
        end
        p.uinstr.src2_is_imm = is_imm;
        r = lcg_next();
        p.rename.robid = r[16 +: `ROBID_W];
        p.rename.pdst = r[24 +: `PRF_IDX_W];
        p.rename.psrc1 = psrc1;
        p.rename.psrc1_pend = p1;
        p.rename.psrc2 = psrc2;
        p.rename.psrc2_pend = p2;
        return p;
    endfunction

    function automatic logic wakes(input logic [1:0] wen, input t_prf_idx [1:0] wreg,
                                   input t_prf_idx preg);
        return (wen[0] && wreg[0] == preg) || (wen[1] && wreg[1] == preg);
    endfunction

    // Records one step and advances the model across its rising edge
    task automatic add_step(input int test, input logic dv, input t_disp_pkt dp,
                            input logic [1:0] wen, input t_prf_idx r0, input t_prf_idx r1,
                            input logic ir);
        t_step      st;
        t_model_ent ent;
        int         pick;
        st.test = test;
        st.disp_valid = dv;
        st.disp_pkt = dp;
        st.wr_en = wen;
        st.wr_reg[0] = r0;
        st.wr_reg[1] = r1;
        st.issue_ready = ir;
        pick = -1;
        for (int i = 0; i < model_q.size(); i++) begin
            if (pick < 0 && !model_q[i].pend1 && !model_q[i].pend2) begin
                pick = i;
            end
        end
        st.exp_disp_ready = (model_q.size() < `RS_NUM_ENTRIES);
        st.exp_issue_valid = (pick >= 0);
        st.exp_pkt = (pick >= 0) ? model_q[pick].pkt : '0;
        step_q.push_back(st);
        if (ir && pick >= 0) begin
            model_q.delete(pick);
        end
        for (int i = 0; i < model_q.size(); i++) begin
            if (wakes(wen, st.wr_reg, model_q[i].pkt.psrc1)) model_q[i].pend1 = 1'b0;
            if (wakes(wen, st.wr_reg, model_q[i].pkt.psrc2)) model_q[i].pend2 = 1'b0;
        end
        if (dv) begin
            ent.pkt = '0;
            ent.pkt.uinstr = dp.uinstr;
            ent.pkt.robid = dp.rename.robid;
            ent.pkt.pdst = dp.rename.pdst;
            ent.pkt.psrc1 = dp.rename.psrc1;
            ent.pkt.psrc2 = dp.rename.psrc2;
            ent.pend1 = dp.rename.psrc1_pend && !wakes(wen, st.wr_reg, dp.rename.psrc1);
            ent.pend2 = dp.rename.psrc2_pend && !dp.uinstr.src2_is_imm &&
                        !wakes(wen, st.wr_reg, dp.rename.psrc2);
            model_q.push_back(ent);
        end
    endtask

    task automatic idle(input int test, input logic ir);
        add_step(test, 1'b0, '0, 2'b00, '0, '0, ir);
    endtask

    task automatic dispatch(input int test, input t_disp_pkt dp, input logic ir);
        add_step(test, 1'b1, dp, 2'b00, '0, '0, ir);
    endtask

    task automatic build_table();
        idle(0, 1'b1);
        dispatch(0, make_pkt(rand_reg(), 1'b0, rand_reg(), 1'b0, 1'b0), 1'b1);
        idle(0, 1'b1);
        idle(0, 1'b1);
        // Wrong register first, then the real one on port 1 and later port 0
        dispatch(1, make_pkt(6'd40, 1'b1, rand_reg(), 1'b0, 1'b0), 1'b1);
        add_step(1, 1'b0, '0, 2'b01, 6'd41, '0, 1'b1);
        add_step(1, 1'b0, '0, 2'b10, '0, 6'd40, 1'b1);
        idle(1, 1'b1);
        dispatch(1, make_pkt(rand_reg(), 1'b0, 6'd42, 1'b1, 1'b0), 1'b1);
        add_step(1, 1'b0, '0, 2'b01, 6'd42, '0, 1'b1);
        idle(1, 1'b1);
        idle(1, 1'b1);
        add_step(2, 1'b1, make_pkt(6'd43, 1'b1, rand_reg(), 1'b0, 1'b0),
                 2'b01, 6'd43, '0, 1'b1);
        idle(2, 1'b1);
        idle(2, 1'b1);
        dispatch(3, make_pkt(rand_reg(), 1'b0, 6'd44, 1'b1, 1'b1), 1'b1);
        idle(3, 1'b1);
        idle(3, 1'b1);
        repeat (3) dispatch(4, make_pkt(rand_reg(), 1'b0, rand_reg(), 1'b0, 1'b0), 1'b0);
        repeat (2) idle(4, 1'b0);
        repeat (4) idle(4, 1'b1);
        // Older entry still pending lets the younger one go first
        dispatch(4, make_pkt(6'd45, 1'b1, rand_reg(), 1'b0, 1'b0), 1'b0);
        dispatch(4, make_pkt(rand_reg(), 1'b0, rand_reg(), 1'b0, 1'b0), 1'b0);
        idle(4, 1'b1);
        add_step(4, 1'b0, '0, 2'b01, 6'd45, '0, 1'b1);
        idle(4, 1'b1);
        idle(4, 1'b1);
        repeat (4) dispatch(5, make_pkt(rand_reg(), 1'b0, rand_reg(), 1'b0, 1'b0), 1'b0);
        idle(5, 1'b0);
        idle(5, 1'b1);
        dispatch(5, make_pkt(rand_reg(), 1'b0, rand_reg(), 1'b0, 1'b0), 1'b0);
        repeat (5) idle(5, 1'b1);
    endtask

    task automatic check_bit(input string test, input string sig, input logic exp,
                             input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            test_errors++;
            $display("CHECK FAILED %s %s: expected %b, actual %b", test, sig, exp, act);
        end
    endtask

    task automatic check_issue(input string test, input t_iss_pkt exp, input t_iss_pkt act);
        checks++;
        if (act !== exp) begin
            errors++;
            test_errors++;
            $display("CHECK FAILED %s issue_pkt: expected %h, actual %h", test, exp, act);
        end
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= timeout_limit) begin
            $display("Timeout: run did not finish within %0d cycles", timeout_limit);
            $display("=== FAIL ===");
            $finish;
        end
    end

    initial begin
        disp_valid = 1'b0;
        disp_pkt = '0;
        issue_ready = 1'b0;
        for (int i = 0; i < `IPRF_NUM_WRITES; i++) begin
            iprf_wr_en[i] = 1'b0;
            iprf_wr_pkt[i] = '0;
        end
        build_table();
        timeout_limit = step_q.size() * 2 + 20;
        @(negedge clk);
        while (reset) @(negedge clk);
        for (int k = 0; k < step_q.size(); k++) begin
            check_bit(test_names[step_q[k].test], "disp_ready",
                      step_q[k].exp_disp_ready, disp_ready);
            check_bit(test_names[step_q[k].test], "issue_valid",
                      step_q[k].exp_issue_valid, issue_valid);
            if (step_q[k].exp_issue_valid) begin
                check_issue(test_names[step_q[k].test], step_q[k].exp_pkt, issue_pkt);
            end
            disp_valid = step_q[k].disp_valid;
            disp_pkt = step_q[k].disp_pkt;
            issue_ready = step_q[k].issue_ready;
            for (int i = 0; i < `IPRF_NUM_WRITES; i++) begin
                iprf_wr_en[i] = step_q[k].wr_en[i];
                iprf_wr_pkt[i].preg = step_q[k].wr_reg[i];
            end
            @(negedge clk);
            if (k == step_q.size() - 1 || step_q[k + 1].test != step_q[k].test) begin
                tests_run++;
                if (test_errors != 0) tests_failed++;
                $display("test %s: %s (%0d errors)", test_names[step_q[k].test],
                         (test_errors == 0) ? "ok" : "failed", test_errors);
                test_errors = 0;
            end
        end
        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

//--- rs_tb_clk.sv
`timescale 1ns/1ps

module rs_tb_clk (
    output logic clk,
    output logic reset
);

    localparam realtime HALF_PERIOD = 50ns;

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    // Reset spans the first five rising edges
    initial begin
        reset = 1'b1;
        repeat (5) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

//--- vlog.f
+incdir+.
instr_pkg.sv
rs_pkg.sv
rs_reg_trk.sv
rs_entry.sv
rs_age_matrix.sv
reservation_station.sv
rs_tb_clk.sv
rs_tb.sv
